// File: source/mvu_macros.svh
`ifndef MVU_MACROS_SVH
`define MVU_MACROS_SVH

// Datapath shape

`define MVU_SIMD       4   // Lanes per entry
`define MVU_TSRCI      4   // Signed activation lane width
`define MVU_TW         4   // Signed weight lane width
`define MVU_TDSTI      16  // Dot product and accumulator width

// Buffering and status

`define MVU_FIFO_DEPTH 4   // Entries between ingress and PE
`define MVU_CNT_W      8   // Finished result counter, wraps

`endif

// File: source/mvu_bus_pkg.sv
`default_nettype none

package mvu_bus_pkg;

   // Register map of the Wishbone slave
   typedef enum logic [1:0] {
      REG_WGT      = 2'd0,  // Weight word, held until next write
      REG_ACT      = 2'd1,  // Activation, push entry
      REG_ACT_LAST = 2'd2,  // Activation, push entry closing the dot product
      REG_STATUS   = 2'd3   // Read only
   } mvu_reg_e;

   // Ingress handshake FSM
   typedef enum logic [1:0] {
      IDLE,        // Waiting for a strobe
      WAIT_SPACE,  // Activation write stalled on full FIFO
      ACK          // One-cycle acknowledge
   } ingress_state_e;

endpackage

`default_nettype wire

// File: source/mvu_arith_pkg.sv
`default_nettype none

`include "mvu_macros.svh"

package mvu_arith_pkg;

   // Activation word, lane 0 in the low bits
   typedef logic [`MVU_SIMD-1:0][`MVU_TSRCI-1:0] act_word_t;

   // Weight word, same lane layout as the activation
   typedef logic [`MVU_SIMD-1:0][`MVU_TW-1:0] wgt_word_t;

   // Full-precision lane product
   typedef logic signed [`MVU_TSRCI+`MVU_TW-1:0] prod_t;

   // Dot product and accumulator word
   typedef logic signed [`MVU_TDSTI-1:0] result_t;

endpackage

`default_nettype wire

// File: source/mvu_wb_ingress.sv
`default_nettype none

`include "mvu_macros.svh"

module mvu_wb_ingress
   import mvu_bus_pkg::*;
   import mvu_arith_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [1:0]  wb_adr,
   input  logic [31:0] wb_dat_w,
   output logic        wb_ack,
   output logic [31:0] wb_dat_r,
   output logic        fifo_push,     // Entry strobe into the FIFO
   output act_word_t   push_act,
   output wgt_word_t   push_wgt,
   output logic        push_last,     // Closes the running dot product
   input  logic        fifo_full,
   input  logic        fifo_empty,
   input  logic        out_v          // Finished result from the PE
);

   ingress_state_e        state;
   ingress_state_e        state_nxt;
   mvu_reg_e              reg_sel;
   wgt_word_t             wgt_q;      // Most recent weight word
   logic [`MVU_CNT_W-1:0] done_cnt;   // Wrapping count of results
   logic [31:0]           status_word;
   logic                  req;
   logic                  act_wr;
   logic                  first_cyc;  // Strobe seen for the first time

   assign reg_sel   = mvu_reg_e'(wb_adr);
   assign req       = wb_cyc && wb_stb;
   assign act_wr    = wb_we && ((reg_sel == REG_ACT) || (reg_sel == REG_ACT_LAST));
   assign first_cyc = (state == IDLE) && req;

   // Entry payload comes straight off the bus, master holds it until ack
   assign push_act  = act_word_t'(wb_dat_w[`MVU_SIMD*`MVU_TSRCI-1:0]);
   assign push_wgt  = wgt_q;
   assign push_last = (reg_sel == REG_ACT_LAST);
   assign wb_ack    = (state == ACK);

   always_comb begin
      status_word = '0;
      status_word[0] = fifo_full;
      status_word[1] = fifo_empty;
      status_word[8 +: `MVU_CNT_W] = done_cnt;
   end

   always_comb begin
      state_nxt = state;
      fifo_push = 1'b0;
      case (state)
         IDLE: begin
            if (req) begin
               if (act_wr && fifo_full) begin
                  state_nxt = WAIT_SPACE;                       // Stall, no ack yet
               end else begin
                  fifo_push = act_wr;                           // Push on first cycle
                  state_nxt = ACK;
               end
            end
         end
         WAIT_SPACE: begin
            if (!wb_cyc) begin
               state_nxt = IDLE;                                // Master gave up
            end else if (!fifo_full) begin
               fifo_push = 1'b1;
               state_nxt = ACK;
            end
         end
         ACK:     state_nxt = IDLE;                             // Ack lasts one cycle
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= IDLE;
         wgt_q    <= '0;
         done_cnt <= '0;
      end else begin
         state <= state_nxt;
         if (first_cyc && wb_we && (reg_sel == REG_WGT)) begin
            wgt_q <= wgt_word_t'(wb_dat_w[`MVU_SIMD*`MVU_TW-1:0]);
         end
         if (out_v) begin
            done_cnt <= done_cnt + `MVU_CNT_W'(1);               // Wraps at 2**CNT_W
         end
      end
   end

   // Read data sampled with the request, valid during ack
   always_ff @(posedge clk) begin
      if (first_cyc && !wb_we) begin
         wb_dat_r <= (reg_sel == REG_STATUS) ? status_word : '0;
      end
   end

   a_ack_in_stb: assert property (@(posedge clk) disable iff (reset)
      wb_ack |-> wb_stb);                                       // Master holds stb until ack

   a_push_not_full: assert property (@(posedge clk) disable iff (reset)
      fifo_push |-> !fifo_full);

endmodule

`default_nettype wire

// File: source/mvu_entry_fifo.sv
`default_nettype none

`include "mvu_macros.svh"

module mvu_entry_fifo
   import mvu_arith_pkg::*;
#(
   parameter int DEPTH = `MVU_FIFO_DEPTH
) (
   input  logic      clk,
   input  logic      reset,
   input  logic      push,
   input  act_word_t push_act,
   input  wgt_word_t push_wgt,
   input  logic      push_last,
   input  logic      pop,
   output act_word_t head_act,   // Show-ahead head entry
   output wgt_word_t head_wgt,
   output logic      head_last,
   output logic      full,
   output logic      empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   act_word_t        mem_act  [DEPTH];
   wgt_word_t        mem_wgt  [DEPTH];
   logic             mem_last [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;      // Occupancy
   logic             do_push;
   logic             do_pop;

   // Circular pointer step, depth need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
   endfunction

   assign do_pop  = pop && !empty;
   assign do_push = push && (!full || pop);      // Full plus pop frees a slot

   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);

   assign head_act  = mem_act[rd_ptr];
   assign head_wgt  = mem_wgt[rd_ptr];
   assign head_last = mem_last[rd_ptr];

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= ptr_inc(wr_ptr);
         if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: count <= count;                 // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem_act[wr_ptr]  <= push_act;
         mem_wgt[wr_ptr]  <= push_wgt;
         mem_last[wr_ptr] <= push_last;
      end
   end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
      pop |-> !empty);

   a_no_push_full: assert property (@(posedge clk) disable iff (reset)
      (push && full) |-> pop);

endmodule

`default_nettype wire

// File: source/mvu_pe_acc.sv
`default_nettype none

module mvu_pe_acc
   import mvu_arith_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    in_v,       // in_sum is valid
   input  logic    in_last,    // Entry closes the dot product
   input  result_t in_sum,
   output logic    out_v,
   output result_t out
);

   result_t acc_q;             // Running total of the open group
   result_t acc_sum;

   assign acc_sum = acc_q + in_sum;

   always_ff @(posedge clk) begin
      if (reset) begin
         acc_q <= '0;
         out_v <= 1'b0;
      end else begin
         out_v <= in_v && in_last;
         if (in_v) begin
            acc_q <= in_last ? '0 : acc_sum;   // Restart on last
         end
      end
   end

   // Total including the last entry
   always_ff @(posedge clk) begin
      if (in_v && in_last) begin
         out <= acc_sum;
      end
   end

   a_out_after_last: assert property (@(posedge clk) disable iff (reset)
      out_v |-> $past(in_v && in_last));

endmodule

`default_nettype wire

// File: source/mvu_pe.sv
`default_nettype none

`include "mvu_macros.svh"

module mvu_pe
   import mvu_arith_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  act_word_t head_act,
   input  wgt_word_t head_wgt,
   input  logic      head_last,
   input  logic      fifo_empty,
   output logic      fifo_pop,
   output logic      out_v,      // One-cycle pulse per dot product
   output result_t   out
);

   act_word_t                    in_act_q;     // Entry taken from the FIFO
   wgt_word_t                    in_wgt_q;
   logic                         in_v_q;
   logic                         in_last_q;
   logic signed [`MVU_TSRCI-1:0] lane_act [`MVU_SIMD];
   logic signed [`MVU_TW-1:0]    lane_wgt [`MVU_SIMD];
   prod_t                        prod_d   [`MVU_SIMD];
   prod_t                        prod_q   [`MVU_SIMD];
   logic                         prod_v_q;
   logic                         prod_last_q;
   result_t                      pair_sum [`MVU_SIMD/2];
   result_t                      tree_sum;     // Unregistered lane total

   assign fifo_pop = !fifo_empty;              // Never stalls, one entry per cycle

   always_ff @(posedge clk) begin
      if (reset) begin
         in_v_q   <= 1'b0;
         prod_v_q <= 1'b0;
      end else begin
         in_v_q   <= fifo_pop;
         prod_v_q <= in_v_q;
      end
   end

   // Input stage
   always_ff @(posedge clk) begin
      if (fifo_pop) begin
         in_act_q  <= head_act;
         in_wgt_q  <= head_wgt;
         in_last_q <= head_last;
      end
   end

   // Lane split and signed multiply
   for (genvar i = 0; i < `MVU_SIMD; i++) begin : g_lane
      assign lane_act[i] = in_act_q[i];
      assign lane_wgt[i] = in_wgt_q[i];
      assign prod_d[i]   = lane_act[i] * lane_wgt[i];   // Both signed, full width
   end

   // Product stage
   always_ff @(posedge clk) begin
      prod_q      <= prod_d;
      prod_last_q <= in_last_q;
   end

   // Adder tree, first level in pairs
   for (genvar j = 0; j < `MVU_SIMD/2; j++) begin : g_tree
      assign pair_sum[j] = result_t'(prod_q[2*j]) + result_t'(prod_q[2*j+1]);
   end

   always_comb begin
      tree_sum = '0;
      for (int k = 0; k < `MVU_SIMD/2; k++) begin
         tree_sum = tree_sum + pair_sum[k];
      end
   end

   mvu_pe_acc mvu_pe_acc_i (
      .clk,
      .reset,
      .in_v    (prod_v_q),
      .in_last (prod_last_q),
      .in_sum  (tree_sum),
      .out_v,
      .out
   );

endmodule

`default_nettype wire

// File: source/mvu_core.sv
`default_nettype none

`include "mvu_macros.svh"

module mvu_core
   import mvu_arith_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [1:0]  wb_adr,
   input  logic [31:0] wb_dat_w,
   output logic        wb_ack,
   output logic [31:0] wb_dat_r,
   output logic        out_v,
   output result_t     out
);

   logic      fifo_push;     // Ingress to FIFO
   act_word_t push_act;
   wgt_word_t push_wgt;
   logic      push_last;
   logic      fifo_full;
   logic      fifo_empty;
   logic      fifo_pop;      // PE to FIFO
   act_word_t head_act;
   wgt_word_t head_wgt;
   logic      head_last;

   mvu_wb_ingress mvu_wb_ingress_i (
      .clk,
      .reset,
      .wb_cyc,
      .wb_stb,
      .wb_we,
      .wb_adr,
      .wb_dat_w,
      .wb_ack,
      .wb_dat_r,
      .fifo_push,
      .push_act,
      .push_wgt,
      .push_last,
      .fifo_full,
      .fifo_empty,
      .out_v                 // Counts finished results
   );

   mvu_entry_fifo #(
      .DEPTH (`MVU_FIFO_DEPTH)
   ) mvu_entry_fifo_i (
      .clk,
      .reset,
      .push      (fifo_push),
      .push_act,
      .push_wgt,
      .push_last,
      .pop       (fifo_pop),
      .head_act,
      .head_wgt,
      .head_last,
      .full      (fifo_full),
      .empty     (fifo_empty)
   );

   mvu_pe mvu_pe_i (
      .clk,
      .reset,
      .head_act,
      .head_wgt,
      .head_last,
      .fifo_empty,
      .fifo_pop,
      .out_v,
      .out
   );

endmodule

`default_nettype wire

// File: verification/mvu_core_checker.sv
`default_nettype none

`include "mvu_macros.svh"

module mvu_core_checker
   import mvu_bus_pkg::*;
   import mvu_arith_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [1:0]  wb_adr,
   input  logic [31:0] wb_dat_w,
   input  logic        wb_ack,
   input  logic [31:0] wb_dat_r,
   input  logic        out_v,
   input  result_t     out,
   input  logic        test_done,      // Stimulus finished, look for leftovers
   output int          errors,
   output int          checks,
   output int          pending,        // Results expected but not yet seen
   output logic        end_checked
);

   result_t                          exp_q[$];    // Expected dot products in order
   int                               model_sum;   // Open group, full precision
   logic [`MVU_SIMD*`MVU_TW-1:0]     model_wgt;
   logic [`MVU_CNT_W-1:0]            model_cnt;   // Results closed since reset
   int                               err_cnt = 0;
   int                               chk_cnt = 0;
   int                               pend_cnt = 0;
   logic                             end_flag = 1'b0;

   assign errors      = err_cnt;
   assign checks      = chk_cnt;
   assign pending     = pend_cnt;
   assign end_checked = end_flag;

   // Sum of the signed lane products of one entry
   function automatic int entry_sum(input logic [`MVU_SIMD*`MVU_TSRCI-1:0] act,
                                    input logic [`MVU_SIMD*`MVU_TW-1:0] wgt);
      int s;
      s = 0;
      for (int i = 0; i < `MVU_SIMD; i++) begin
         s += int'($signed(act[`MVU_TSRCI*i +: `MVU_TSRCI]))
            * int'($signed(wgt[`MVU_TW*i +: `MVU_TW]));
      end
      return s;
   endfunction

   task automatic compare_result();
      result_t exp;
      if (exp_q.size() == 0) begin
         $display("ERROR t=%0t: out_v pulsed while no result was expected", $time);
         err_cnt++;
      end else begin
         exp = exp_q.pop_front();
         chk_cnt++;
         if (out !== exp) begin
            $display("CHECK FAILED t=%0t out: expected %0d, actual %0d", $time, exp, out);
            err_cnt++;
         end
      end
   endtask

   task automatic compare_status();
      logic [31:0] exp;
      exp = '0;
      exp[1] = 1'b1;                                 // Drained, so empty and not full
      exp[8 +: `MVU_CNT_W] = model_cnt;              // Wraps like the DUT counter
      chk_cnt++;
      if (wb_dat_r !== exp) begin
         $display("CHECK FAILED t=%0t wb_dat_r: expected %h, actual %h", $time, exp, wb_dat_r);
         err_cnt++;
      end
   endtask

   task automatic track_bus();
      if (wb_we) begin
         case (mvu_reg_e'(wb_adr))
            REG_WGT: model_wgt = wb_dat_w[`MVU_SIMD*`MVU_TW-1:0];
            REG_ACT: model_sum += entry_sum(wb_dat_w[`MVU_SIMD*`MVU_TSRCI-1:0], model_wgt);
            REG_ACT_LAST: begin
               model_sum += entry_sum(wb_dat_w[`MVU_SIMD*`MVU_TSRCI-1:0], model_wgt);
               exp_q.push_back(result_t'(model_sum));  // Truncated like the accumulator
               model_sum = 0;
               model_cnt = model_cnt + `MVU_CNT_W'(1);
            end
            default: ;                                 // Status is read only
         endcase
      end else if (mvu_reg_e'(wb_adr) == REG_STATUS) begin
         compare_status();
      end
   endtask

   // Everything sampled mid-cycle, away from the driving edge
   always @(negedge clk) begin
      if (reset) begin
         if (exp_q.size() != 0) begin
            $display("ERROR t=%0t: %0d expected results were dropped by reset",
                     $time, exp_q.size());
            err_cnt++;
            exp_q.delete();
         end
         model_sum = 0;                                // Partial group is discarded
         model_wgt = '0;
         model_cnt = '0;
      end else begin
         if (out_v) compare_result();
         if (wb_cyc && wb_stb && wb_ack) track_bus();
         if (test_done && !end_flag) begin
            if (exp_q.size() != 0) begin
               $display("ERROR t=%0t: %0d expected results never appeared on out",
                        $time, exp_q.size());
               err_cnt++;
            end
            end_flag = 1'b1;
         end
      end
      pend_cnt = exp_q.size();
   end

endmodule

`default_nettype wire

// File: verification/mvu_core_tb.sv
`default_nettype none

`include "mvu_macros.svh"

module mvu_core_tb
   import mvu_bus_pkg::*;
   import mvu_arith_pkg::*;
();

   localparam int BURST_LEN    = 2 * `MVU_FIFO_DEPTH + 2;   // Longer than the FIFO
   localparam int SINGLE_TXNS  = 20 * 3;                    // Weight, last, status
   localparam int GROUP_TXNS   = 8 * 16;                    // Worst case group
   localparam int EXTREME_TXNS = 16 * 18 + 122;
   localparam int BURST_TXNS   = 3 * (BURST_LEN + 2);
   localparam int RESET_TXNS   = 2 * 9;
   localparam int MAX_CYCLES   = 20 * (SINGLE_TXNS + GROUP_TXNS + EXTREME_TXNS
                                      + BURST_TXNS + RESET_TXNS) + 100;

   logic        clk;
   logic        reset;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [1:0]  wb_adr;
   logic [31:0] wb_dat_w;
   logic        wb_ack;
   logic [31:0] wb_dat_r;
   logic        out_v;
   result_t     out;
   logic        test_done;
   int          errors;
   int          checks;
   int          pending;
   logic        end_checked;
   logic [31:0] lfsr_state;                  // Stimulus source

   mvu_core mvu_core_i (
      .clk,
      .reset,
      .wb_cyc,
      .wb_stb,
      .wb_we,
      .wb_adr,
      .wb_dat_w,
      .wb_ack,
      .wb_dat_r,
      .out_v,
      .out
   );

   mvu_core_checker mvu_core_checker_i (
      .clk,
      .reset,
      .wb_cyc,
      .wb_stb,
      .wb_we,
      .wb_adr,
      .wb_dat_w,
      .wb_ack,
      .wb_dat_r,
      .out_v,
      .out,
      .test_done,
      .errors,
      .checks,
      .pending,
      .end_checked
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic lfsr_bit();
      lfsr_state = lfsr_next(lfsr_state);
      return lfsr_state[0];
   endfunction

   function automatic logic [15:0] random_word();
      logic [15:0] w;
      w = '0;
      for (int i = 0; i < 16; i++) begin
         w = {w[14:0], lfsr_bit()};
      end
      return w;
   endfunction

   function automatic int random_below(input int bound, input int nbits);
      int v;
      v = 0;
      for (int i = 0; i < nbits; i++) begin
         v = 2 * v + (lfsr_bit() ? 1 : 0);
      end
      return v % bound;
   endfunction

   // Each select bit picks -8 or 7 for its lane
   function automatic logic [15:0] extreme_word(input logic [3:0] sel);
      logic [15:0] w;
      for (int i = 0; i < 4; i++) begin
         w[4*i +: 4] = sel[i] ? 4'h8 : 4'h7;
      end
      return w;
   endfunction

   // Classic cycle held until ack and closed on the next edge
   task automatic bus_cycle(input logic we, input mvu_reg_e adr, input logic [15:0] data);
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= {16'h0000, data};
      do @(negedge clk); while (!wb_ack);
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic write_weight(input logic [15:0] data);
      bus_cycle(1'b1, REG_WGT, data);
   endtask

   task automatic write_act(input logic [15:0] data, input logic last);
      bus_cycle(1'b1, last ? REG_ACT_LAST : REG_ACT, data);
   endtask

   // Status read once the checker has seen every expected result
   task automatic drain_and_status();
      do @(posedge clk); while (pending != 0);
      repeat (2) @(posedge clk);
      bus_cycle(1'b0, REG_STATUS, 16'h0000);
   endtask

   task automatic pulse_reset();
      @(posedge clk);
      reset <= 1'b1;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
   endtask

   task automatic run_single_products();
      for (int g = 0; g < 20; g++) begin
         write_weight(random_word());
         write_act(random_word(), 1'b1);
         drain_and_status();
      end
   endtask

   task automatic run_accumulation();
      int n;
      for (int g = 0; g < 8; g++) begin
         write_weight(random_word());
         n = 2 + random_below(5, 3);          // 2 to 6 entries before the last
         for (int i = 0; i < n; i++) begin
            if (lfsr_bit()) write_weight(random_word());
            write_act(random_word(), 1'b0);
         end
         write_act(random_word(), 1'b1);
         drain_and_status();
      end
   endtask

   task automatic run_extremes();
      for (int ws = 0; ws < 16; ws++) begin
         write_weight(extreme_word(ws[3:0]));
         for (int as = 0; as < 16; as++) begin
            write_act(extreme_word(as[3:0]), as == 15);
         end
         drain_and_status();
      end
      write_weight(16'h8888);                 // -8 in every lane
      for (int i = 0; i < 120; i++) begin
         write_act(16'h8888, i == 119);        // 120 x 4 x 64 stays below 2**15
      end
      drain_and_status();
   endtask

   task automatic run_burst();
      for (int b = 0; b < 3; b++) begin
         write_weight(random_word());
         for (int i = 0; i < BURST_LEN; i++) begin
            write_act(random_word(), i == BURST_LEN - 1);
         end
         drain_and_status();
      end
   endtask

   task automatic run_reset_mid_group();
      for (int r = 0; r < 2; r++) begin
         write_weight(random_word());
         for (int i = 0; i < 3; i++) begin
            write_act(random_word(), 1'b0);
         end
         pulse_reset();                       // Open group is abandoned
         write_weight(random_word());
         write_act(random_word(), 1'b0);
         write_act(random_word(), 1'b0);
         write_act(random_word(), 1'b1);
         drain_and_status();
      end
   endtask

   initial begin
      lfsr_state = 32'hf6b2;
      reset      = 1'b1;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = 2'd0;
      wb_dat_w   = '0;
      test_done  = 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      run_single_products();
      run_accumulation();
      run_extremes();
      run_burst();
      run_reset_mid_group();
      test_done <= 1'b1;
      do @(posedge clk); while (!end_checked);
      $display("Closing count: %0d errors in %0d checks", errors, checks);
      if (errors == 0 && checks > 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // Watchdog sized from the bus traffic of all tests
   initial begin
      int cycle_cnt;
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
source/mvu_bus_pkg.sv
source/mvu_arith_pkg.sv
source/mvu_wb_ingress.sv
source/mvu_entry_fifo.sv
source/mvu_pe_acc.sv
source/mvu_pe.sv
source/mvu_core.sv
verification/mvu_core_checker.sv
verification/mvu_core_tb.sv

// File: Makefile
TOP := mvu_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o V$(TOP)

# Pipeline status comes from grep, so a missing pass line fails the target
run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "Simulation finished: PASS" > /dev/null

lint:
	verilator --lint-only --timing --assert -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
